/* include/dsp_core_defines.svh */
`ifndef DSP_CORE_DEFINES_SVH
`define DSP_CORE_DEFINES_SVH

// sample and register width.
`define DSP_DATA_W 16

// depth of the instruction store and of the block register file.
`define DSP_N_BLOCKS 16

`define DSP_N_CHANNELS 16

// number of multiply-add lanes behind the dispatcher.
`define DSP_N_LANES 2

`define DSP_IN_CHANNEL 1
`define DSP_OUT_CHANNEL 0

// depth of every small pipeline queue.
`define DSP_FIFO_DEPTH 2

`endif

/* source/dsp_isa_pkg.sv */
`default_nettype none

`include "dsp_core_defines.svh"

package dsp_isa_pkg;

	typedef logic signed [`DSP_DATA_W - 1:0] sample_t;
	typedef logic [$clog2(`DSP_N_BLOCKS) - 1:0] block_addr_t;
	typedef logic [$clog2(`DSP_N_CHANNELS) - 1:0] chan_addr_t;

	// only the multiply-add is implemented, any other code is skipped.
	typedef enum logic [4:0] {
		OP_MADD = 5'd0
	} opcode_e;

	typedef struct packed {
		logic [1:0] unused;
		opcode_e opcode;
		logic sat_disable;
		logic [4:0] shift;
		logic c_reg;		// a set flag reads block register src[0].
		logic b_reg;
		logic a_reg;
		chan_addr_t src_c;
		chan_addr_t src_b;
		chan_addr_t src_a;
		chan_addr_t dest;
	} instr_t;

endpackage

`default_nettype wire

/* source/dsp_pipe_pkg.sv */
`default_nettype none

`include "dsp_core_defines.svh"

package dsp_pipe_pkg;

	// one multiply-add with its operands already fetched.
	typedef struct packed {
		dsp_isa_pkg::sample_t a;
		dsp_isa_pkg::sample_t b;
		dsp_isa_pkg::sample_t c;
		logic [4:0] shift;
		logic sat_disable;
		dsp_isa_pkg::chan_addr_t dest;
	} madd_op_t;

	typedef struct packed {
		dsp_isa_pkg::chan_addr_t dest;
		dsp_isa_pkg::sample_t value;
	} madd_result_t;

	typedef struct packed {
		logic en;
		dsp_isa_pkg::chan_addr_t addr;
		dsp_isa_pkg::sample_t value;
	} chan_write_t;

endpackage

`default_nettype wire

/* source/stage_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dsp_core_defines.svh"

module stage_fifo #(
	parameter type payload_t = logic
) (
	input  logic clk,
	input  logic reset,
	input  payload_t in_data,
	input  logic in_valid,
	input  logic out_ready,
	output logic in_ready,
	output payload_t out_data,
	output logic out_valid
);
	localparam int depth = `DSP_FIFO_DEPTH;
	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);

	payload_t entries [depth];
	logic [ptr_w - 1:0] wr_ptr;
	logic [ptr_w - 1:0] rd_ptr;
	logic [cnt_w - 1:0] count;
	logic push;
	logic pop;

	assign in_ready = (count != cnt_w'(depth));
	assign out_valid = (count != '0);
	assign out_data = entries[rd_ptr];
	assign push = in_valid && in_ready;
	assign pop = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (push)
			entries[wr_ptr] <= in_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + cnt_w'(push) - cnt_w'(pop);
		end
	end

	// an offer that meets a full queue is held until the queue takes it.
	assert property (@(posedge clk) disable iff (reset)
		in_valid && !in_ready |=> in_valid && $stable(in_data))
		else $error("stage_fifo input offer was dropped while the queue was full");

endmodule

`default_nettype wire

/* source/block_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dsp_core_defines.svh"

module block_sequencer (
	input  logic clk,
	input  logic reset,
	input  logic enable,
	input  logic tick,
	input  logic full_reset,
	input  logic instr_write,
	input  logic reg_write,
	input  dsp_isa_pkg::block_addr_t block_target,
	input  logic reg_target,
	input  dsp_isa_pkg::instr_t instr_value,
	input  dsp_isa_pkg::sample_t reg_value,
	input  dsp_isa_pkg::sample_t [2:0] chan_data,
	input  logic op_ready,
	input  logic period_done,
	output dsp_isa_pkg::chan_addr_t [2:0] chan_addr,
	output dsp_pipe_pkg::madd_op_t op,
	output logic op_valid,
	output logic period_start,
	output logic [$clog2(`DSP_N_BLOCKS + 1) - 1:0] op_total,
	output logic busy,
	output logic resetting
);
	import dsp_isa_pkg::*;

	localparam int cnt_w = $clog2(`DSP_N_BLOCKS + 1);

	instr_t instrs [`DSP_N_BLOCKS];
	sample_t block_regs [`DSP_N_BLOCKS][2];
	logic [cnt_w - 1:0] n_blocks_running;
	logic [cnt_w - 1:0] total_q;
	logic [cnt_w - 1:0] issued;
	block_addr_t cur_blk;
	block_addr_t sweep_addr;
	instr_t cur_instr;
	sample_t opnd_a;
	sample_t opnd_b;
	sample_t opnd_c;
	logic issue_slot;

	assign period_start = tick && enable && !busy && !resetting;
	assign cur_instr = instrs[cur_blk];
	assign chan_addr[0] = cur_instr.src_a;
	assign chan_addr[1] = cur_instr.src_b;
	assign chan_addr[2] = cur_instr.src_c;
	assign issue_slot = busy && (issued != total_q) && (!op_valid || op_ready);

	always_comb begin
		opnd_a = cur_instr.a_reg ? block_regs[cur_blk][cur_instr.src_a[0]] : chan_data[0];
		opnd_b = cur_instr.b_reg ? block_regs[cur_blk][cur_instr.src_b[0]] : chan_data[1];
		opnd_c = cur_instr.c_reg ? block_regs[cur_blk][cur_instr.src_c[0]] : chan_data[2];
	end

	// operations this period, known up front so that commit can tell when it is done.
	always_comb begin
		op_total = '0;
		for (int i = 0; i < `DSP_N_BLOCKS; i++) begin
			if (i < n_blocks_running && instrs[i].opcode == OP_MADD)
				op_total = op_total + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (resetting)
			instrs[sweep_addr] <= '0;
		else if (instr_write)
			instrs[block_target] <= instr_value;
		if (reg_write)
			block_regs[block_target][reg_target] <= reg_value;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			n_blocks_running <= '0;
			resetting <= 1'b0;
			sweep_addr <= '0;
		end else if (full_reset) begin
			n_blocks_running <= '0;
			resetting <= 1'b1;
			sweep_addr <= '0;
		end else if (resetting) begin
			sweep_addr <= sweep_addr + 1'b1;
			if (sweep_addr == block_addr_t'(`DSP_N_BLOCKS - 1))
				resetting <= 1'b0;	// one store entry per cycle.
		end else if (instr_write && cnt_w'(block_target) >= n_blocks_running) begin
			n_blocks_running <= cnt_w'(block_target) + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || full_reset) begin
			busy <= 1'b0;
			op_valid <= 1'b0;
			cur_blk <= '0;
			issued <= '0;
			total_q <= '0;
		end else if (period_start) begin
			busy <= 1'b1;
			cur_blk <= '0;
			issued <= '0;
			total_q <= op_total;
		end else if (busy) begin
			if (op_ready)
				op_valid <= 1'b0;
			if (issue_slot) begin
				cur_blk <= cur_blk + 1'b1;
				if (cur_instr.opcode == OP_MADD) begin
					op_valid <= 1'b1;
					issued <= issued + 1'b1;
				end
			end
			if (period_done)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (issue_slot) begin
			op <= '{
				a: opnd_a,
				b: opnd_b,
				c: opnd_c,
				shift: cur_instr.shift,
				sat_disable: cur_instr.sat_disable,
				dest: cur_instr.dest
			};
		end
	end

	assert property (@(posedge clk) disable iff (reset) resetting |-> !op_valid)
		else $error("operation offered during full reset");

endmodule

`default_nettype wire

/* source/channel_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dsp_core_defines.svh"

module channel_bank (
	input  logic clk,
	input  logic reset,
	input  logic full_reset,
	input  logic period_start,
	input  dsp_isa_pkg::sample_t sample_in,
	input  dsp_isa_pkg::chan_addr_t [2:0] chan_addr,
	input  dsp_pipe_pkg::chan_write_t chan_write,
	output dsp_isa_pkg::sample_t [2:0] chan_data,
	output dsp_isa_pkg::sample_t sample_out
);
	import dsp_isa_pkg::*;

	sample_t snap_bank [`DSP_N_CHANNELS];	// read by every block of the period.
	sample_t write_bank [`DSP_N_CHANNELS];

	always_comb begin
		for (int k = 0; k < 3; k++)
			chan_data[k] = snap_bank[chan_addr[k]];
	end

	always_ff @(posedge clk) begin
		if (reset || full_reset) begin
			for (int i = 0; i < `DSP_N_CHANNELS; i++) begin
				snap_bank[i] <= '0;
				write_bank[i] <= '0;
			end
		end else begin
			if (period_start) begin
				for (int i = 0; i < `DSP_N_CHANNELS; i++)
					snap_bank[i] <= write_bank[i];
				snap_bank[`DSP_IN_CHANNEL] <= sample_in;	// the new sample wins over the old one.
			end
			if (chan_write.en)
				write_bank[chan_write.addr] <= chan_write.value;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			sample_out <= '0;
		else if (period_start)
			sample_out <= write_bank[`DSP_OUT_CHANNEL];
	end

endmodule

`default_nettype wire

/* source/op_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dsp_core_defines.svh"

module op_dispatch (
	input  logic clk,
	input  logic reset,
	input  dsp_pipe_pkg::madd_op_t op,
	input  logic op_valid,
	input  logic [`DSP_N_LANES - 1:0] lane_ready,
	output logic op_ready,
	output dsp_pipe_pkg::madd_op_t lane_op,
	output logic [`DSP_N_LANES - 1:0] lane_valid
);
	import dsp_pipe_pkg::*;

	localparam int turn_w = (`DSP_N_LANES > 1) ? $clog2(`DSP_N_LANES) : 1;

	logic [turn_w - 1:0] turn;
	logic head_valid;
	logic head_ready;

	stage_fifo #(.payload_t(madd_op_t)) u_op_fifo (
		.clk(clk),
		.reset(reset),
		.in_data(op),
		.in_valid(op_valid),
		.in_ready(op_ready),
		.out_data(lane_op),
		.out_valid(head_valid),
		.out_ready(head_ready)
	);

	// the head only goes to the lane whose turn it is, commit drains in the same order.
	assign head_ready = lane_ready[turn];

	always_comb begin
		lane_valid = '0;
		lane_valid[turn] = head_valid;
	end

	always_ff @(posedge clk) begin
		if (reset)
			turn <= '0;
		else if (head_valid && head_ready)
			turn <= (turn == turn_w'(`DSP_N_LANES - 1)) ? '0 : turn + 1'b1;
	end

	// an offered operation waits at its lane until that lane takes it.
	assert property (@(posedge clk) disable iff (reset)
		(|lane_valid) && !(|(lane_valid & lane_ready))
		|=> $stable(lane_valid) && $stable(lane_op))
		else $error("lane offer changed before the lane took it");

endmodule

`default_nettype wire

/* source/madd_lane.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dsp_core_defines.svh"

module madd_lane (
	input  logic clk,
	input  logic reset,
	input  dsp_pipe_pkg::madd_op_t in_op,
	input  logic in_valid,
	input  logic out_ready,
	output logic in_ready,
	output dsp_pipe_pkg::madd_result_t out_result,
	output logic out_valid
);
	import dsp_isa_pkg::*;
	import dsp_pipe_pkg::*;

	localparam int prod_w = 2 * `DSP_DATA_W;
	localparam sample_t max_sample = {1'b0, {(`DSP_DATA_W - 1){1'b1}}};
	localparam sample_t min_sample = {1'b1, {(`DSP_DATA_W - 1){1'b0}}};

	logic stage_en;
	logic mul_valid;
	logic signed [prod_w - 1:0] mul_prod;
	sample_t mul_c;
	logic [4:0] mul_shift;
	logic mul_sat_disable;
	chan_addr_t mul_dest;
	logic add_valid;
	logic signed [prod_w - 1:0] add_sum;
	logic add_sat_disable;
	chan_addr_t add_dest;
	madd_result_t sat_result;

	assign in_ready = stage_en;	// a full output queue freezes the whole lane.

	always_ff @(posedge clk) begin
		if (reset) begin
			mul_valid <= 1'b0;
			add_valid <= 1'b0;
		end else if (stage_en) begin
			mul_valid <= in_valid;
			add_valid <= mul_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (stage_en) begin
			mul_prod <= in_op.a * in_op.b;
			mul_c <= in_op.c;
			mul_shift <= in_op.shift;
			mul_sat_disable <= in_op.sat_disable;
			mul_dest <= in_op.dest;
			add_sum <= (mul_prod >>> mul_shift) + mul_c;
			add_sat_disable <= mul_sat_disable;
			add_dest <= mul_dest;
		end
	end

	always_comb begin
		sat_result.dest = add_dest;
		if (add_sat_disable)
			sat_result.value = add_sum[`DSP_DATA_W - 1:0];	// wraps.
		else if (add_sum > max_sample)
			sat_result.value = max_sample;
		else if (add_sum < min_sample)
			sat_result.value = min_sample;
		else
			sat_result.value = add_sum[`DSP_DATA_W - 1:0];
	end

	// the queue entry is the third stage of the lane.
	stage_fifo #(.payload_t(madd_result_t)) u_result_fifo (
		.clk(clk),
		.reset(reset),
		.in_data(sat_result),
		.in_valid(add_valid),
		.in_ready(stage_en),
		.out_data(out_result),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

endmodule

`default_nettype wire

/* source/commit_master.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dsp_core_defines.svh"

module commit_master (
	input  logic clk,
	input  logic reset,
	input  logic period_start,
	input  logic [$clog2(`DSP_N_BLOCKS + 1) - 1:0] op_total,
	input  dsp_pipe_pkg::madd_result_t [`DSP_N_LANES - 1:0] lane_result,
	input  logic [`DSP_N_LANES - 1:0] lane_valid,
	output logic [`DSP_N_LANES - 1:0] lane_ready,
	output dsp_pipe_pkg::chan_write_t chan_write,
	output logic period_done
);
	import dsp_pipe_pkg::*;

	localparam int cnt_w = $clog2(`DSP_N_BLOCKS + 1);
	localparam int turn_w = (`DSP_N_LANES > 1) ? $clog2(`DSP_N_LANES) : 1;

	logic active;
	logic [turn_w - 1:0] turn;
	logic [cnt_w - 1:0] total_q;
	logic [cnt_w - 1:0] committed;
	logic [cnt_w - 1:0] committed_next;
	logic fire;
	madd_result_t head;

	// the turn runs on across periods, so it stays aligned with the dispatcher.
	assign head = lane_result[turn];
	assign fire = active && lane_valid[turn];
	assign committed_next = committed + cnt_w'(fire);
	assign period_done = active && (committed_next == total_q);

	always_comb begin
		lane_ready = '0;
		lane_ready[turn] = active;
	end

	assign chan_write = '{en: fire, addr: head.dest, value: head.value};

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			turn <= '0;
			total_q <= '0;
			committed <= '0;
		end else if (period_start) begin
			active <= 1'b1;
			total_q <= op_total;
			committed <= '0;
		end else if (active) begin
			committed <= committed_next;
			if (fire)
				turn <= (turn == turn_w'(`DSP_N_LANES - 1)) ? '0 : turn + 1'b1;
			if (period_done)
				active <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* source/dsp_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dsp_core_defines.svh"

module dsp_core (
	input  logic clk,
	input  logic reset,
	input  logic enable,
	input  logic tick,
	input  dsp_isa_pkg::sample_t sample_in,
	input  logic instr_write,
	input  logic reg_write,
	input  dsp_isa_pkg::block_addr_t block_target,
	input  logic reg_target,
	input  dsp_isa_pkg::instr_t instr_value,
	input  dsp_isa_pkg::sample_t reg_value,
	input  logic full_reset,
	output dsp_isa_pkg::sample_t sample_out,
	output logic busy,
	output logic resetting
);
	import dsp_isa_pkg::*;
	import dsp_pipe_pkg::*;

	logic pipe_reset;
	chan_addr_t [2:0] chan_addr;
	sample_t [2:0] chan_data;
	madd_op_t seq_op;
	logic seq_op_valid;
	logic seq_op_ready;
	logic period_start;
	logic period_done;
	logic [$clog2(`DSP_N_BLOCKS + 1) - 1:0] op_total;
	madd_op_t lane_op;
	logic [`DSP_N_LANES - 1:0] lane_in_valid;
	logic [`DSP_N_LANES - 1:0] lane_in_ready;
	madd_result_t [`DSP_N_LANES - 1:0] lane_result;
	logic [`DSP_N_LANES - 1:0] lane_out_valid;
	logic [`DSP_N_LANES - 1:0] lane_out_ready;
	chan_write_t chan_write;

	assign pipe_reset = reset || resetting;	// in-flight work is dropped by a full reset.

	block_sequencer u_sequencer (
		.clk(clk),
		.reset(reset),
		.enable(enable),
		.tick(tick),
		.full_reset(full_reset),
		.instr_write(instr_write),
		.reg_write(reg_write),
		.block_target(block_target),
		.reg_target(reg_target),
		.instr_value(instr_value),
		.reg_value(reg_value),
		.chan_data(chan_data),
		.op_ready(seq_op_ready),
		.period_done(period_done),
		.chan_addr(chan_addr),
		.op(seq_op),
		.op_valid(seq_op_valid),
		.period_start(period_start),
		.op_total(op_total),
		.busy(busy),
		.resetting(resetting)
	);

	channel_bank u_channels (
		.clk(clk),
		.reset(reset),
		.full_reset(full_reset),
		.period_start(period_start),
		.sample_in(sample_in),
		.chan_addr(chan_addr),
		.chan_write(chan_write),
		.chan_data(chan_data),
		.sample_out(sample_out)
	);

	op_dispatch u_dispatch (
		.clk(clk),
		.reset(pipe_reset),
		.op(seq_op),
		.op_valid(seq_op_valid),
		.lane_ready(lane_in_ready),
		.op_ready(seq_op_ready),
		.lane_op(lane_op),
		.lane_valid(lane_in_valid)
	);

	for (genvar k = 0; k < `DSP_N_LANES; k++) begin : g_lane
		madd_lane u_lane (
			.clk(clk),
			.reset(pipe_reset),
			.in_op(lane_op),
			.in_valid(lane_in_valid[k]),
			.out_ready(lane_out_ready[k]),
			.in_ready(lane_in_ready[k]),
			.out_result(lane_result[k]),
			.out_valid(lane_out_valid[k])
		);
	end

	commit_master u_commit (
		.clk(clk),
		.reset(pipe_reset),
		.period_start(period_start),
		.op_total(op_total),
		.lane_result(lane_result),
		.lane_valid(lane_out_valid),
		.lane_ready(lane_out_ready),
		.chan_write(chan_write),
		.period_done(period_done)
	);

endmodule

`default_nettype wire

/* tests/dsp_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dsp_core_defines.svh"

module dsp_core_tb;
	import dsp_isa_pkg::*;

	// accepted ticks per test: 8, 6, 10, 40 and 5, plus one dropped tick.
	localparam int total_ticks = 70;
	localparam int timeout_cycles = total_ticks * 60;

	logic clk;
	logic reset;
	logic enable;
	logic tick;
	sample_t sample_in;
	logic instr_write;
	logic reg_write;
	block_addr_t block_target;
	logic reg_target;
	instr_t instr_value;
	sample_t reg_value;
	logic full_reset;
	sample_t sample_out;
	logic busy;
	logic resetting;
	logic accepted;
	logic lane0_active;
	logic lane1_active;

	instr_t m_store [`DSP_N_BLOCKS];
	sample_t m_regs [`DSP_N_BLOCKS][2];
	sample_t m_wb [`DSP_N_CHANNELS];
	int m_nrun;
	sample_t exp_out;
	int error_count = 0;
	int errors_at_start = 0;
	int pass_count = 0;
	int fail_count = 0;
	int cycle_count = 0;
	int overlap_cycles = 0;
	int overlap_start;

	dsp_core u_dut (
		.clk(clk),
		.reset(reset),
		.enable(enable),
		.tick(tick),
		.sample_in(sample_in),
		.instr_write(instr_write),
		.reg_write(reg_write),
		.block_target(block_target),
		.reg_target(reg_target),
		.instr_value(instr_value),
		.reg_value(reg_value),
		.full_reset(full_reset),
		.sample_out(sample_out),
		.busy(busy),
		.resetting(resetting)
	);

	assign accepted = tick && enable && !busy && !resetting;
	assign lane0_active = u_dut.g_lane[0].u_lane.mul_valid || u_dut.g_lane[0].u_lane.add_valid
		|| u_dut.lane_out_valid[0];
	assign lane1_active = u_dut.g_lane[1].u_lane.mul_valid || u_dut.g_lane[1].u_lane.add_valid
		|| u_dut.lane_out_valid[1];

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (lane0_active && lane1_active)
			overlap_cycles++;	// both lanes hold work in the same cycle.
		if (cycle_count >= timeout_cycles) begin
			$display("run timed out after %0d cycles", cycle_count);
			$display("TESTS FAILED");
			$finish;
		end
	end

	assert property (@(posedge clk) disable iff (reset) accepted |=> sample_out == exp_out)
		else begin
			$display("mismatch sample_out: got %h, expected %h", sample_out, exp_out);
			error_count++;
		end

	assert property (@(posedge clk) disable iff (reset) (tick && !accepted) |=> $stable(sample_out))
		else begin
			$display("sample_out changed after a dropped tick");
			error_count++;
		end

	function automatic sample_t madd_ref(input sample_t a, input sample_t b, input sample_t c,
		input logic [4:0] shift, input logic sat_off);
		int prod;
		int sum;
		prod = int'(a) * int'(b);
		prod = prod >>> shift;
		sum = prod + int'(c);
		if (sat_off)
			return sum[15:0];
		if (sum > 32767)
			return 16'sh7fff;
		if (sum < -32768)
			return 16'sh8000;
		return sum[15:0];
	endfunction

	// reg_sel bit 0 selects a register for a, bit 1 for b and bit 2 for c.
	function automatic instr_t make_instr(input int dest, input int src_a, input int src_b,
		input int src_c, input logic [2:0] reg_sel, input int shift, input logic sat_off,
		input int opcode);
		instr_t ins;
		ins = '0;
		ins.dest = chan_addr_t'(dest);
		ins.src_a = chan_addr_t'(src_a);
		ins.src_b = chan_addr_t'(src_b);
		ins.src_c = chan_addr_t'(src_c);
		ins.a_reg = reg_sel[0];
		ins.b_reg = reg_sel[1];
		ins.c_reg = reg_sel[2];
		ins.shift = 5'(shift);
		ins.sat_disable = sat_off;
		ins.opcode = opcode_e'(opcode);
		return ins;
	endfunction

	task automatic write_instr(input int blk, input instr_t value);
		block_target = block_addr_t'(blk);
		instr_value = value;
		instr_write = 1'b1;
		@(negedge clk);
		instr_write = 1'b0;
		m_store[blk] = value;
		if (blk >= m_nrun)
			m_nrun = blk + 1;
	endtask

	task automatic write_reg(input int blk, input int idx, input sample_t value);
		block_target = block_addr_t'(blk);
		reg_target = idx[0];
		reg_value = value;
		reg_write = 1'b1;
		@(negedge clk);
		reg_write = 1'b0;
		m_regs[blk][idx] = value;
	endtask

	// dest = src * 0x4000 >>> shift, so a shift of 14 is a plain copy.
	task automatic write_scaled(input int blk, input int dest, input int src, input int shift);
		write_reg(blk, 0, 16'sh4000);
		write_reg(blk, 1, 16'sh0000);
		write_instr(blk, make_instr(dest, src, 0, 1, 3'b110, shift, 1'b0, 0));
	endtask

	task automatic pulse_full_reset();
		int high_cycles;
		full_reset = 1'b1;
		@(negedge clk);
		full_reset = 1'b0;
		high_cycles = 0;
		while (resetting) begin
			high_cycles++;
			@(negedge clk);
		end
		assert (high_cycles == `DSP_N_BLOCKS)
			else begin
				$display("resetting stayed high for %0d cycles instead of %0d", high_cycles,
					`DSP_N_BLOCKS);
				error_count++;
			end
		m_nrun = 0;
		for (int i = 0; i < `DSP_N_BLOCKS; i++)
			m_store[i] = '0;
		for (int i = 0; i < `DSP_N_CHANNELS; i++)
			m_wb[i] = '0;
	endtask

	// the model runs the whole period before the tick is driven.
	task automatic run_tick(input sample_t in_sample);
		sample_t snap [`DSP_N_CHANNELS];
		sample_t a;
		sample_t b;
		sample_t c;
		instr_t ins;
		exp_out = m_wb[`DSP_OUT_CHANNEL];
		for (int i = 0; i < `DSP_N_CHANNELS; i++)
			snap[i] = m_wb[i];
		snap[`DSP_IN_CHANNEL] = in_sample;
		for (int blk = 0; blk < m_nrun; blk++) begin
			ins = m_store[blk];
			if (ins.opcode == OP_MADD) begin
				a = ins.a_reg ? m_regs[blk][ins.src_a[0]] : snap[ins.src_a];
				b = ins.b_reg ? m_regs[blk][ins.src_b[0]] : snap[ins.src_b];
				c = ins.c_reg ? m_regs[blk][ins.src_c[0]] : snap[ins.src_c];
				m_wb[ins.dest] = madd_ref(a, b, c, ins.shift, ins.sat_disable);
			end
		end
		sample_in = in_sample;
		tick = 1'b1;
		@(negedge clk);
		tick = 1'b0;
		assert (busy)
			else begin
				$display("tick was not accepted");
				error_count++;
			end
		while (busy)
			@(negedge clk);
	endtask

	task automatic drop_tick();
		enable = 1'b0;
		tick = 1'b1;
		sample_in = sample_t'($urandom);
		@(negedge clk);
		tick = 1'b0;
		enable = 1'b1;
	endtask

	task automatic load_random_program(input int n_blocks);
		int opcode;
		for (int blk = 0; blk < n_blocks; blk++) begin
			write_reg(blk, 0, sample_t'($urandom));
			write_reg(blk, 1, sample_t'($urandom));
			opcode = ($urandom % 4 == 0) ? 1 + $urandom % 31 : 0;	// mostly multiply-adds.
			write_instr(blk, make_instr($urandom % 16, $urandom % 16, $urandom % 16,
				$urandom % 16, 3'($urandom), $urandom % 16, ($urandom % 4 == 0), opcode));
		end
	endtask

	task automatic start_test();
		errors_at_start = error_count;
	endtask

	task automatic end_test(input string name);
		if (error_count == errors_at_start) begin
			pass_count++;
			$display("test %s: ok", name);
		end else begin
			fail_count++;
			$display("test %s: failed with %0d errors", name, error_count - errors_at_start);
		end
	endtask

	initial begin
		void'($urandom(17416));
		reset = 1'b1;
		enable = 1'b1;
		tick = 1'b0;
		sample_in = '0;
		instr_write = 1'b0;
		reg_write = 1'b0;
		block_target = '0;
		reg_target = 1'b0;
		instr_value = '0;
		reg_value = '0;
		full_reset = 1'b0;
		m_nrun = 0;
		exp_out = '0;
		for (int i = 0; i < `DSP_N_CHANNELS; i++)
			m_wb[i] = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		assert (!busy && !resetting)
			else begin
				$display("busy or resetting is high after reset");
				error_count++;
			end
		assert (sample_out == '0)
			else begin
				$display("mismatch sample_out after reset: got %h, expected 0000", sample_out);
				error_count++;
			end

		start_test();
		pulse_full_reset();
		write_scaled(0, `DSP_OUT_CHANNEL, `DSP_IN_CHANNEL, 14);
		repeat (4)
			run_tick(sample_t'($urandom));
		drop_tick();
		repeat (4)
			run_tick(sample_t'($urandom));
		end_test("pass_through");

		start_test();
		pulse_full_reset();
		write_reg(0, 0, 16'sh7fff);
		write_reg(0, 1, 16'sh0000);
		write_instr(0, make_instr(0, 1, 0, 1, 3'b110, 0, 1'b0, 0));
		run_tick(16'sh7000);
		run_tick(-16'sh7000);
		run_tick(16'sh0003);
		write_instr(0, make_instr(0, 1, 0, 1, 3'b110, 0, 1'b1, 0));	// now the sum wraps.
		run_tick(16'sh7000);
		run_tick(-16'sh7000);
		run_tick(16'sh0003);
		end_test("saturation");

		start_test();
		pulse_full_reset();
		write_scaled(0, 3, `DSP_IN_CHANNEL, 14);
		write_scaled(1, 4, 3, 14);
		write_scaled(2, `DSP_OUT_CHANNEL, 4, 14);
		repeat (5)
			run_tick(sample_t'($urandom % 4096));
		write_scaled(3, `DSP_OUT_CHANNEL, 3, 13);
		repeat (5)
			run_tick(sample_t'($urandom % 4096));
		end_test("snapshot");

		start_test();
		overlap_start = overlap_cycles;
		for (int prog = 0; prog < 4; prog++) begin
			pulse_full_reset();
			load_random_program(prog == 0 ? `DSP_N_BLOCKS : 1 + $urandom % `DSP_N_BLOCKS);
			repeat (10)
				run_tick(sample_t'($urandom));
		end
		assert (overlap_cycles > overlap_start)
			else begin
				$display("the two lanes never held operations at the same time");
				error_count++;
			end
		end_test("random_programs");

		start_test();
		pulse_full_reset();
		write_scaled(0, `DSP_OUT_CHANNEL, `DSP_IN_CHANNEL, 14);
		run_tick(16'sh1234);
		run_tick(16'sh0567);
		pulse_full_reset();
		repeat (3)
			run_tick(sample_t'($urandom));
		end_test("full_reset");

		$display("tests: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0 && error_count == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* dsp_core.f */
+incdir+include
source/dsp_isa_pkg.sv
source/dsp_pipe_pkg.sv
source/stage_fifo.sv
source/block_sequencer.sv
source/channel_bank.sv
source/op_dispatch.sv
source/madd_lane.sv
source/commit_master.sv
source/dsp_core.sv
tests/dsp_core_tb.sv

/* Bender.yml */
package:
  name: dsp_core

export_include_dirs:
  - include

sources:
  - source/dsp_isa_pkg.sv
  - source/dsp_pipe_pkg.sv
  - source/stage_fifo.sv
  - source/block_sequencer.sv
  - source/channel_bank.sv
  - source/op_dispatch.sv
  - source/madd_lane.sv
  - source/commit_master.sv
  - source/dsp_core.sv
  - target: test
    files:
      - tests/dsp_core_tb.sv
